// ==== bench/node_output_properties.sv ====
// Handshake, stall and idle assertions for the output change tracker
`timescale 1ns/1ns
`default_nettype none

module node_output_properties (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  idle_o,
    input  node_pkg::output_vec_t core_outputs_i,
    input  node_pkg::row_t        msg_row_o,
    input  node_pkg::col_t        msg_col_o,
    input  node_pkg::input_idx_t  msg_index_o,
    input  logic                  msg_seq_o,
    input  logic                  msg_state_o,
    input  logic                  msg_valid_o,
    input  logic                  msg_ready_i,
    input  logic                  loopback_valid_o
);

    // ==================================================
    // Outbound handshake
    // ==================================================

    // Valid held until taken
    a_valid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        msg_valid_o && !msg_ready_i |=> msg_valid_o)
        else $error("msg_valid_o dropped before msg_ready_i");

    // Fields frozen during a stall
    a_data_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        msg_valid_o && !msg_ready_i
        |=> $stable({msg_row_o, msg_col_o, msg_index_o, msg_seq_o, msg_state_o}))
        else $error("message fields changed while stalled");

    // ==================================================
    // Idle and loopback
    // ==================================================

    // Settled tracker stays idle while the core outputs hold
    a_idle_rest: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        idle_o ##1 $stable(core_outputs_i) |-> idle_o)
        else $error("idle_o dropped with no change of core_outputs_i");

    // Pulse not repeated while its message waits
    a_lb_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        loopback_valid_o && !msg_ready_i |=> !loopback_valid_o)
        else $error("loopback_valid_o repeated during a stall");

endmodule : node_output_properties

bind output_change_tracker node_output_properties u_properties (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .idle_o           (idle_o),
    .core_outputs_i   (core_outputs_i),
    .msg_row_o        (msg_row_o),
    .msg_col_o        (msg_col_o),
    .msg_index_o      (msg_index_o),
    .msg_seq_o        (msg_seq_o),
    .msg_state_o      (msg_state_o),
    .msg_valid_o      (msg_valid_o),
    .msg_ready_i      (msg_ready_i),
    .loopback_valid_o (loopback_valid_o)
);

`default_nettype wire

// ==== bench/tb_node_output_unit.sv ====
// Testbench for the node output unit, random core activity checked against a reference model
`timescale 1ns/1ns
`default_nettype none

module tb_node_output_unit;

    logic                  clk_i;
    logic                  rst_n_i;
    logic                  cfg_ptr_we_i;
    node_pkg::output_idx_t cfg_ptr_idx_i;
    node_pkg::store_addr_t cfg_ptr_base_i;
    node_pkg::store_addr_t cfg_ptr_final_i;
    logic                  cfg_ptr_actv_i;
    logic                  cfg_map_we_i;
    node_pkg::store_addr_t cfg_map_addr_i;
    node_pkg::store_data_t cfg_map_data_i;
    node_pkg::output_vec_t core_outputs_i;
    logic                  idle_o;
    node_pkg::row_t        msg_row_o;
    node_pkg::col_t        msg_col_o;
    node_pkg::input_idx_t  msg_index_o;
    logic                  msg_seq_o;
    logic                  msg_state_o;
    logic                  msg_valid_o;
    logic                  msg_ready_i;
    node_pkg::input_idx_t  loopback_index_o;
    logic                  loopback_state_o;
    logic                  loopback_valid_o;

    // Model copy of the configuration
    node_pkg::store_data_t map_copy [node_pkg::STORE_DEPTH];
    node_pkg::store_addr_t base_copy [node_pkg::NUM_OUTPUTS];
    node_pkg::store_addr_t final_copy [node_pkg::NUM_OUTPUTS];
    node_pkg::output_vec_t actv_copy;
    // Recorded state as the model sees it
    node_pkg::output_vec_t model_state;
    // Entry below its loopback bit with the new state appended
    logic [node_pkg::STORE_DATA_W-1:0] exp_msg_q [$];
    // Input index with the new state appended
    logic [node_pkg::INPUT_IDX_W:0]    exp_lb_q [$];
    node_pkg::output_vec_t             stim [24];

    integer seed;
    int     error_count;
    int     msg_count;
    int     lb_count;
    logic   random_ready;
    logic   timed_out;

    node_output_unit u_node_output_unit (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .cfg_ptr_we_i     (cfg_ptr_we_i),
        .cfg_ptr_idx_i    (cfg_ptr_idx_i),
        .cfg_ptr_base_i   (cfg_ptr_base_i),
        .cfg_ptr_final_i  (cfg_ptr_final_i),
        .cfg_ptr_actv_i   (cfg_ptr_actv_i),
        .cfg_map_we_i     (cfg_map_we_i),
        .cfg_map_addr_i   (cfg_map_addr_i),
        .cfg_map_data_i   (cfg_map_data_i),
        .core_outputs_i   (core_outputs_i),
        .idle_o           (idle_o),
        .msg_row_o        (msg_row_o),
        .msg_col_o        (msg_col_o),
        .msg_index_o      (msg_index_o),
        .msg_seq_o        (msg_seq_o),
        .msg_state_o      (msg_state_o),
        .msg_valid_o      (msg_valid_o),
        .msg_ready_i      (msg_ready_i),
        .loopback_index_o (loopback_index_o),
        .loopback_state_o (loopback_state_o),
        .loopback_valid_o (loopback_valid_o)
    );

    // 8 ns clock
    always #4 clk_i = ~clk_i;

    // ==================================================
    // Configuration writes
    // ==================================================

    task automatic write_map(input int addr);
        node_pkg::store_data_t data;
        data           = node_pkg::store_data_t'($random(seed));
        map_copy[addr] = data;
        @(posedge clk_i);
        cfg_map_we_i   <= 1'b1;
        cfg_map_addr_i <= node_pkg::store_addr_t'(addr);
        cfg_map_data_i <= data;
    endtask

    task automatic write_pointer(input int idx);
        node_pkg::store_addr_t base;
        int                    last;
        logic                  actv;
        base = node_pkg::store_addr_t'($random(seed));
        // Runs of one to four entries clipped at the top of the store
        last = int'(base) + ($random(seed) & 3);
        if (last > node_pkg::STORE_DEPTH - 1) begin
            last = node_pkg::STORE_DEPTH - 1;
        end
        // Output 0 always mapped and output 3 never
        actv = (idx == 0) || ((idx != 3) && (($random(seed) & 7) != 0));
        base_copy[idx]  = base;
        final_copy[idx] = node_pkg::store_addr_t'(last);
        actv_copy[idx]  = actv;
        @(posedge clk_i);
        cfg_ptr_we_i    <= 1'b1;
        cfg_ptr_idx_i   <= node_pkg::output_idx_t'(idx);
        cfg_ptr_base_i  <= base;
        cfg_ptr_final_i <= node_pkg::store_addr_t'(last);
        cfg_ptr_actv_i  <= actv;
    endtask

    // ==================================================
    // Reference model and checks
    // ==================================================

    // One item per mapped entry of each changed output in ascending order
    task automatic predict_round(input node_pkg::output_vec_t next_out);
        node_pkg::store_data_t entry;
        for (int i = 0; i < node_pkg::NUM_OUTPUTS; i++) begin
            if (next_out[i] != model_state[i]) begin
                if (actv_copy[i]) begin
                    for (int a = base_copy[i]; a <= final_copy[i]; a++) begin
                        entry = map_copy[a];
                        exp_msg_q.push_back({entry[node_pkg::STORE_DATA_W-2:0], next_out[i]});
                        // Top bit of the entry asks for a loopback
                        if (entry[node_pkg::STORE_DATA_W-1]) begin
                            exp_lb_q.push_back({entry[node_pkg::INPUT_IDX_W:1], next_out[i]});
                        end
                    end
                end
                model_state[i] = next_out[i];
            end
        end
    endtask

    task automatic report_mismatch(input string name, input logic [7:0] got,
                                   input logic [7:0] exp);
        $display("Mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        error_count++;
    endtask

    task automatic check_message;
        node_pkg::row_t       row;
        node_pkg::col_t       col;
        node_pkg::input_idx_t idx;
        logic                 seq;
        logic                 state;
        if (exp_msg_q.size() == 0) begin
            $display("Message transferred while none was expected at %0t", $time);
            error_count++;
        end else begin
            {row, col, idx, seq, state} = exp_msg_q.pop_front();
            if (msg_row_o !== row) report_mismatch("msg_row_o", msg_row_o, row);
            if (msg_col_o !== col) report_mismatch("msg_col_o", msg_col_o, col);
            if (msg_index_o !== idx) report_mismatch("msg_index_o", msg_index_o, idx);
            if (msg_seq_o !== seq) report_mismatch("msg_seq_o", msg_seq_o, seq);
            if (msg_state_o !== state) report_mismatch("msg_state_o", msg_state_o, state);
            msg_count++;
        end
    endtask

    task automatic check_loopback;
        node_pkg::input_idx_t idx;
        logic                 state;
        if (exp_lb_q.size() == 0) begin
            $display("Loopback pulse while none was expected at %0t", $time);
            error_count++;
        end else begin
            {idx, state} = exp_lb_q.pop_front();
            if (loopback_index_o !== idx) begin
                report_mismatch("loopback_index_o", loopback_index_o, idx);
            end
            if (loopback_state_o !== state) begin
                report_mismatch("loopback_state_o", loopback_state_o, state);
            end
            lb_count++;
        end
    endtask

    // Outputs sampled mid-cycle away from the driving edge
    always @(negedge clk_i) begin
        if (rst_n_i && msg_valid_o && msg_ready_i) begin
            check_message();
        end
        if (rst_n_i && loopback_valid_o) begin
            check_loopback();
        end
    end

    // ==================================================
    // Stimulus rounds
    // ==================================================

    task automatic wait_idle;
        logic seen;
        seen = 1'b0;
        for (int c = 0; c < 2000 && !seen; c++) begin
            @(posedge clk_i);
            msg_ready_i <= random_ready ? (($random(seed) & 3) != 0) : 1'b1;
            @(negedge clk_i);
            seen = idle_o;
        end
        if (!seen) begin
            $display("Timeout, idle_o stayed low for 2000 cycles at %0t", $time);
            error_count++;
            timed_out = 1'b1;
        end
    endtask

    task automatic run_round(input node_pkg::output_vec_t next_out);
        if (!timed_out) begin
            predict_round(next_out);
            @(posedge clk_i);
            core_outputs_i <= next_out;
            wait_idle();
            if (exp_msg_q.size() != 0 || exp_lb_q.size() != 0) begin
                $display("Outputs 0x%h left %0d messages and %0d loopbacks unseen",
                         next_out, exp_msg_q.size(), exp_lb_q.size());
                error_count++;
                exp_msg_q.delete();
                exp_lb_q.delete();
            end
        end
    endtask

    initial begin
        seed            = 33399;
        clk_i           = 1'b0;
        rst_n_i         = 1'b0;
        cfg_ptr_we_i    = 1'b0;
        cfg_ptr_idx_i   = '0;
        cfg_ptr_base_i  = '0;
        cfg_ptr_final_i = '0;
        cfg_ptr_actv_i  = 1'b0;
        cfg_map_we_i    = 1'b0;
        cfg_map_addr_i  = '0;
        cfg_map_data_i  = '0;
        core_outputs_i  = '0;
        msg_ready_i     = 1'b1;
        random_ready    = 1'b0;
        timed_out       = 1'b0;
        model_state     = '0;
        error_count     = 0;
        msg_count       = 0;
        lb_count        = 0;
        repeat (16) @(posedge clk_i);
        rst_n_i <= 1'b1;
        // Load the whole store and every pointer while outputs rest at zero
        for (int a = 0; a < node_pkg::STORE_DEPTH; a++) write_map(a);
        for (int i = 0; i < node_pkg::NUM_OUTPUTS; i++) write_pointer(i);
        @(posedge clk_i);
        cfg_map_we_i <= 1'b0;
        cfg_ptr_we_i <= 1'b0;
        // Quiet after reset
        for (int c = 0; c < 20; c++) begin
            @(negedge clk_i);
            if (!idle_o) begin
                $display("idle_o low with no output change at %0t", $time);
                error_count++;
            end
        end
        // Single output then all then no change at all
        run_round(8'h01);
        run_round(8'hff);
        run_round(8'hff);
        for (int r = 0; r < 24; r++) stim[r] = node_pkg::output_vec_t'($random(seed));
        // Same sequence with ready high and then with random back-pressure
        for (int r = 0; r < 24; r++) run_round(stim[r]);
        run_round(8'hff);
        random_ready = 1'b1;
        for (int r = 0; r < 24; r++) run_round(stim[r]);
        $display("Checked %0d messages and %0d loopbacks, %0d errors",
                 msg_count, lb_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule : tb_node_output_unit

`default_nettype wire

// ==== filelist.f ====
source/node_pkg.sv
source/lead_zero_count.sv
source/output_pointer_table.sv
source/output_map_ram.sv
source/output_change_tracker.sv
source/node_output_unit.sv
bench/node_output_properties.sv
bench/tb_node_output_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the node output unit testbench with Verilator
rm -f sim.log && \
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module tb_node_output_unit -Mdir obj_dir -o sim_tb && \
./obj_dir/sim_tb | tee sim.log
grep -qs "^TESTS PASSED$" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// ==== source/lead_zero_count.sv ====
// Priority encoder returning the position of the lowest set bit of a vector
`timescale 1ns/1ns
`default_nettype none

module lead_zero_count #(
    parameter  int WIDTH = 8,
    localparam int IDX_W = $clog2(WIDTH)
) (
    input  logic [WIDTH-1:0] vec_i,
    output logic [IDX_W-1:0] index_o,
    output logic             any_o
);

    // Index equals the count of zeros below the first set bit
    always_comb begin
        index_o = '0;
        // Walk down from the top, the lowest set bit is the last to win
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (vec_i[i]) begin
                index_o = IDX_W'(i);
            end
        end
    end

    // Any bit set at all
    assign any_o = |vec_i;

endmodule : lead_zero_count

`default_nettype wire

// ==== source/node_output_unit.sv ====
// Node output unit top level joining pointer table, mapping store and tracker
`timescale 1ns/1ns
`default_nettype none

module node_output_unit (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    // Pointer table configuration
    input  logic                  cfg_ptr_we_i,
    input  node_pkg::output_idx_t cfg_ptr_idx_i,
    input  node_pkg::store_addr_t cfg_ptr_base_i,
    input  node_pkg::store_addr_t cfg_ptr_final_i,
    input  logic                  cfg_ptr_actv_i,
    // Mapping store configuration
    input  logic                  cfg_map_we_i,
    input  node_pkg::store_addr_t cfg_map_addr_i,
    input  node_pkg::store_data_t cfg_map_data_i,
    // Core outputs and status
    input  node_pkg::output_vec_t core_outputs_i,
    output logic                  idle_o,
    // Outbound message
    output node_pkg::row_t        msg_row_o,
    output node_pkg::col_t        msg_col_o,
    output node_pkg::input_idx_t  msg_index_o,
    output logic                  msg_seq_o,
    output logic                  msg_state_o,
    output logic                  msg_valid_o,
    input  logic                  msg_ready_i,
    // Loopback
    output node_pkg::input_idx_t  loopback_index_o,
    output logic                  loopback_state_o,
    output logic                  loopback_valid_o
);

    // Table to tracker
    node_pkg::store_addr_t [node_pkg::NUM_OUTPUTS-1:0] ptr_base;
    node_pkg::store_addr_t [node_pkg::NUM_OUTPUTS-1:0] ptr_final;
    node_pkg::output_vec_t                             ptr_actv;
    // Tracker and store
    node_pkg::store_addr_t                             store_addr;
    logic                                              store_rd_en;
    node_pkg::store_data_t                             store_rd_data;

    output_pointer_table u_pointer_table (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .cfg_ptr_we_i    (cfg_ptr_we_i),
        .cfg_ptr_idx_i   (cfg_ptr_idx_i),
        .cfg_ptr_base_i  (cfg_ptr_base_i),
        .cfg_ptr_final_i (cfg_ptr_final_i),
        .cfg_ptr_actv_i  (cfg_ptr_actv_i),
        .ptr_base_o      (ptr_base),
        .ptr_final_o     (ptr_final),
        .ptr_actv_o      (ptr_actv)
    );

    output_map_ram u_map_ram (
        .clk_i          (clk_i),
        .cfg_map_we_i   (cfg_map_we_i),
        .cfg_map_addr_i (cfg_map_addr_i),
        .cfg_map_data_i (cfg_map_data_i),
        .rd_en_i        (store_rd_en),
        .rd_addr_i      (store_addr),
        .rd_data_o      (store_rd_data)
    );

    output_change_tracker u_tracker (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .idle_o           (idle_o),
        .core_outputs_i   (core_outputs_i),
        .ptr_base_i       (ptr_base),
        .ptr_final_i      (ptr_final),
        .ptr_actv_i       (ptr_actv),
        .store_addr_o     (store_addr),
        .store_rd_en_o    (store_rd_en),
        .store_rd_data_i  (store_rd_data),
        .msg_row_o        (msg_row_o),
        .msg_col_o        (msg_col_o),
        .msg_index_o      (msg_index_o),
        .msg_seq_o        (msg_seq_o),
        .msg_state_o      (msg_state_o),
        .msg_valid_o      (msg_valid_o),
        .msg_ready_i      (msg_ready_i),
        .loopback_index_o (loopback_index_o),
        .loopback_state_o (loopback_state_o),
        .loopback_valid_o (loopback_valid_o)
    );

endmodule : node_output_unit

`default_nettype wire

// ==== source/node_pkg.sv ====
// Node output unit shared widths, sizes and vector types
`default_nettype none

package node_pkg;

    // ==================================================
    // Core output vector
    // ==================================================

    // Outputs driven by the node core
    localparam int NUM_OUTPUTS  = 8;
    localparam int OUTPUT_IDX_W = $clog2(NUM_OUTPUTS);

    // ==================================================
    // Mapping store
    // ==================================================

    // Routing entries shared by all outputs
    localparam int STORE_DEPTH  = 32;
    localparam int STORE_ADDR_W = $clog2(STORE_DEPTH);

    // Mesh addressing of the target node
    localparam int ROW_W        = 4;
    localparam int COL_W        = 4;

    // Input index on the target node
    localparam int INPUT_IDX_W  = 3;

    // Entry layout from the top bit: loopback, row, column, input index, sequential
    localparam int STORE_DATA_W = 1 + ROW_W + COL_W + INPUT_IDX_W + 1;

    // ==================================================
    // Vector types
    // ==================================================

    // One bit per core output
    typedef logic [NUM_OUTPUTS-1:0]  output_vec_t;
    typedef logic [OUTPUT_IDX_W-1:0] output_idx_t;

    // Mapping store address and entry
    typedef logic [STORE_ADDR_W-1:0] store_addr_t;
    typedef logic [STORE_DATA_W-1:0] store_data_t;

    // Decoded entry fields
    typedef logic [ROW_W-1:0]        row_t;
    typedef logic [COL_W-1:0]        col_t;
    typedef logic [INPUT_IDX_W-1:0]  input_idx_t;

endpackage : node_pkg

`default_nettype wire

// ==== source/output_change_tracker.sv ====
// Tracks core output changes and emits one signal-state message per mapping entry
`timescale 1ns/1ns
`default_nettype none

module output_change_tracker (
    input  logic                                           clk_i,
    input  logic                                           rst_n_i,
    // Status
    output logic                                           idle_o,
    // From the core
    input  node_pkg::output_vec_t                          core_outputs_i,
    // Pointer table
    input  node_pkg::store_addr_t [node_pkg::NUM_OUTPUTS-1:0] ptr_base_i,
    input  node_pkg::store_addr_t [node_pkg::NUM_OUTPUTS-1:0] ptr_final_i,
    input  node_pkg::output_vec_t                          ptr_actv_i,
    // Mapping store
    output node_pkg::store_addr_t                          store_addr_o,
    output logic                                           store_rd_en_o,
    input  node_pkg::store_data_t                          store_rd_data_i,
    // Outbound message
    output node_pkg::row_t                                 msg_row_o,
    output node_pkg::col_t                                 msg_col_o,
    output node_pkg::input_idx_t                           msg_index_o,
    output logic                                           msg_seq_o,
    output logic                                           msg_state_o,
    output logic                                           msg_valid_o,
    input  logic                                           msg_ready_i,
    // Loopback to own inputs
    output node_pkg::input_idx_t                           loopback_index_o,
    output logic                                           loopback_state_o,
    output logic                                           loopback_valid_o
);

    // Change detection
    node_pkg::output_vec_t state_q;
    node_pkg::output_vec_t state_next;
    node_pkg::output_vec_t flip_mask;
    node_pkg::output_vec_t change_vec;
    node_pkg::output_idx_t pick_index;
    logic                  pick_any;
    // Detect register
    logic                  det_valid_q;
    node_pkg::output_idx_t det_index_q;
    logic                  det_value_q;
    logic                  det_load;
    logic                  det_actv;
    logic                  det_done;
    // Address walk
    logic                  walk_busy_q;
    node_pkg::store_addr_t walk_next_q;
    node_pkg::store_addr_t issue_addr;
    logic                  issue;
    logic                  issue_last;
    // Fetch address register
    logic                  fetch_valid_q;
    node_pkg::store_addr_t fetch_addr_q;
    logic                  fetch_value_q;
    // Delay line across the RAM read
    logic                  ram_valid_q;
    logic                  ram_value_q;
    // Fetched register
    logic                  fe_valid_q;
    logic                  fe_value_q;
    node_pkg::store_data_t fe_data_q;
    logic                  fe_lb;
    node_pkg::row_t        fe_row;
    node_pkg::col_t        fe_col;
    node_pkg::input_idx_t  fe_idx;
    logic                  fe_seq;
    // Back-pressure
    logic                  stall;
    logic                  adv;

    // ==================================================
    // Change detection
    // ==================================================

    // Held message not taken, freeze everything
    assign stall = msg_valid_o && !msg_ready_i;
    assign adv   = !stall;

    // Flip the recorded bit once the held output is finished
    assign flip_mask  = det_done ? (node_pkg::output_vec_t'(1) << det_index_q) : '0;
    assign state_next = state_q ^ flip_mask;

    // Compare against the next state so a finished output is not picked again
    assign change_vec = core_outputs_i ^ state_next;

    lead_zero_count #(
        .WIDTH   (node_pkg::NUM_OUTPUTS)
    ) u_change_pick (
        .vec_i   (change_vec),
        .index_o (pick_index),
        .any_o   (pick_any)
    );

    // Refill when empty or when the held output completes
    assign det_load = !det_valid_q || det_done;

    // ==================================================
    // Fetch address walk
    // ==================================================

    assign det_actv   = det_valid_q && ptr_actv_i[det_index_q];
    // First entry from the base pointer, then count up
    assign issue_addr = walk_busy_q ? walk_next_q : ptr_base_i[det_index_q];
    assign issue      = adv && det_actv;
    assign issue_last = issue && (issue_addr == ptr_final_i[det_index_q]);

    // Unmapped output needs no fetch and retires at once
    assign det_done = det_valid_q && (!ptr_actv_i[det_index_q] || issue_last);

    // RAM read only moves when the pipe moves
    assign store_addr_o  = fetch_addr_q;
    assign store_rd_en_o = fetch_valid_q && adv;

    // ==================================================
    // Entry decode and outputs
    // ==================================================

    assign {fe_lb, fe_row, fe_col, fe_idx, fe_seq} = fe_data_q;

    // Loopback shares the message register
    assign loopback_index_o = msg_index_o;
    assign loopback_state_o = msg_state_o;

    // Nothing pending, nothing in flight
    assign idle_o = !(pick_any || det_valid_q || fetch_valid_q || ram_valid_q
                      || fe_valid_q || msg_valid_o);

    // Control state
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q          <= '0;
            det_valid_q      <= 1'b0;
            walk_busy_q      <= 1'b0;
            fetch_valid_q    <= 1'b0;
            ram_valid_q      <= 1'b0;
            fe_valid_q       <= 1'b0;
            msg_valid_o      <= 1'b0;
            loopback_valid_o <= 1'b0;
        end else begin
            state_q <= state_next;
            if (det_load) begin
                det_valid_q <= pick_any;
            end
            if (issue) begin
                walk_busy_q <= !issue_last;
            end
            // Valid bits shift together, hold on stall
            if (adv) begin
                fetch_valid_q    <= issue;
                ram_valid_q      <= fetch_valid_q;
                fe_valid_q       <= ram_valid_q;
                msg_valid_o      <= fe_valid_q;
                loopback_valid_o <= fe_valid_q && fe_lb;
            end else begin
                // One pulse per entry, not repeated while stalled
                loopback_valid_o <= 1'b0;
            end
        end
    end

    // Payload, qualified by the valid bits above
    always_ff @(posedge clk_i) begin
        if (det_load) begin
            det_index_q <= pick_index;
            det_value_q <= core_outputs_i[pick_index];
        end
        if (issue) begin
            walk_next_q   <= issue_addr + 1'b1;
            fetch_addr_q  <= issue_addr;
            fetch_value_q <= det_value_q;
        end
        if (adv) begin
            ram_value_q <= fetch_value_q;
            fe_value_q  <= ram_value_q;
            fe_data_q   <= store_rd_data_i;
        end
        // New message only when the old one has gone
        if (adv && fe_valid_q) begin
            msg_row_o   <= fe_row;
            msg_col_o   <= fe_col;
            msg_index_o <= fe_idx;
            msg_seq_o   <= fe_seq;
            msg_state_o <= fe_value_q;
        end
    end

endmodule : output_change_tracker

`default_nettype wire

// ==== source/output_map_ram.sv ====
// Mapping store RAM with a config write port and a registered read port
`timescale 1ns/1ns
`default_nettype none

module output_map_ram (
    input  logic                  clk_i,
    // Configuration write
    input  logic                  cfg_map_we_i,
    input  node_pkg::store_addr_t cfg_map_addr_i,
    input  node_pkg::store_data_t cfg_map_data_i,
    // Read port from the tracker
    input  logic                  rd_en_i,
    input  node_pkg::store_addr_t rd_addr_i,
    output node_pkg::store_data_t rd_data_o
);

    // Routing entries
    node_pkg::store_data_t mem [node_pkg::STORE_DEPTH];

    // Config write, only while the tracker is idle
    always_ff @(posedge clk_i) begin
        if (cfg_map_we_i) begin
            mem[cfg_map_addr_i] <= cfg_map_data_i;
        end
    end

    // Data one cycle after the enable
    // Holds the last entry while the read is off, so a stalled fetch stays put
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule : output_map_ram

`default_nettype wire

// ==== source/output_pointer_table.sv ====
// Per-output base, final and active pointer registers written over a config port
`timescale 1ns/1ns
`default_nettype none

module output_pointer_table (
    input  logic                                           clk_i,
    input  logic                                           rst_n_i,
    // Configuration write
    input  logic                                           cfg_ptr_we_i,
    input  node_pkg::output_idx_t                          cfg_ptr_idx_i,
    input  node_pkg::store_addr_t                          cfg_ptr_base_i,
    input  node_pkg::store_addr_t                          cfg_ptr_final_i,
    input  logic                                           cfg_ptr_actv_i,
    // Pointers for every output, flattened
    output node_pkg::store_addr_t [node_pkg::NUM_OUTPUTS-1:0] ptr_base_o,
    output node_pkg::store_addr_t [node_pkg::NUM_OUTPUTS-1:0] ptr_final_o,
    output node_pkg::output_vec_t                          ptr_actv_o
);

    // ==================================================
    // Active flags
    // ==================================================

    // All outputs start unmapped
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ptr_actv_o <= '0;
        end else if (cfg_ptr_we_i) begin
            ptr_actv_o[cfg_ptr_idx_i] <= cfg_ptr_actv_i;
        end
    end

    // ==================================================
    // Address range
    // ==================================================

    // First and last mapping entry of each output
    // Only looked at when the matching active flag is set
    always_ff @(posedge clk_i) begin
        if (cfg_ptr_we_i) begin
            ptr_base_o[cfg_ptr_idx_i]  <= cfg_ptr_base_i;
            ptr_final_o[cfg_ptr_idx_i] <= cfg_ptr_final_i;
        end
    end

endmodule : output_pointer_table

`default_nettype wire
